// ==== design/icache.sv ====
`default_nettype none

module icache #(
  parameter int sets_p = 64,
  localparam int index_width_lp = $clog2(sets_p),
  localparam int tag_width_lp = icache_pkg::paddr_width_gp - index_width_lp
                                - icache_pkg::block_offset_width_gp
) (
  input  wire                                     clk_i,
  input  wire                                     reset_i,
  // fetch side
  input  wire                                     vaddr_v_i,
  input  wire  [icache_pkg::vaddr_width_gp-1:0]   vaddr_i,
  output logic                                    vaddr_ready_o,
  input  wire  [icache_pkg::ptag_width_gp-1:0]    ptag_i,
  input  wire                                     ptag_v_i,
  input  wire                                     poison_i,
  output logic [icache_pkg::instr_width_gp-1:0]   data_o,
  output logic                                    data_v_o,
  output logic                                    miss_o,
  // coherence side
  output logic                                    cache_req_v_o,
  output logic [icache_pkg::paddr_width_gp-1:0]   cache_req_addr_o,
  input  wire                                     cache_req_ready_i,
  output logic                                    cache_req_metadata_v_o,
  output logic [icache_pkg::way_id_width_gp-1:0]  cache_req_repl_way_o,
  input  wire                                     cache_req_complete_i,
  input  wire                                     tag_v_i,
  input  wire  icache_pkg::tag_op_e               tag_op_i,
  input  wire  [index_width_lp-1:0]               tag_index_i,
  input  wire  [icache_pkg::way_id_width_gp-1:0]  tag_way_i,
  input  wire  [tag_width_lp-1:0]                 tag_i,
  output logic                                    tag_ready_o,
  input  wire                                     fill_v_i,
  input  wire  [index_width_lp-1:0]               fill_index_i,
  input  wire  [icache_pkg::way_id_width_gp-1:0]  fill_way_i,
  input  wire  [icache_pkg::block_width_gp-1:0]   fill_data_i,
  output logic                                    fill_ready_o
);

  logic                                          rd_v;
  logic [index_width_lp-1:0]                     rd_index;
  logic [icache_pkg::word_offset_width_gp-1:0]   rd_word;
  logic [icache_pkg::ways_gp-1:0][tag_width_lp-1:0] tags;
  logic [icache_pkg::ways_gp-1:0]                valid;
  logic [icache_pkg::ways_gp-1:0][icache_pkg::dword_width_gp-1:0] words;
  logic                                          tv_v;
  logic [index_width_lp-1:0]                     tv_index;
  logic [icache_pkg::paddr_width_gp-1:0]         tv_addr;
  logic [icache_pkg::ways_gp-1:0]                tv_valid;
  logic                                          hit;
  logic [icache_pkg::way_id_width_gp-1:0]        hit_way;
  logic [icache_pkg::way_id_width_gp-1:0]        repl_way;
  logic                                          tv_miss;
  logic                                          miss_pending;
  logic                                          fetch_ready;

  // arrays belong to fetches in the accept cycle
  assign tag_ready_o = ~rd_v;
  assign fill_ready_o = ~rd_v;
  // request logic sees only the miss of the fetch in TV
  assign tv_miss = tv_v & ~hit;

  icache_lookup #(.sets_p(sets_p)) lookup_i (
    .clk_i, .reset_i, .vaddr_v_i, .vaddr_i, .ptag_i, .ptag_v_i, .poison_i,
    .fetch_ready_i(fetch_ready), .tags_i(tags), .valid_i(valid), .words_i(words),
    .miss_pending_i(miss_pending), .vaddr_ready_o, .rd_v_o(rd_v),
    .rd_index_o(rd_index), .rd_word_o(rd_word), .tv_v_o(tv_v),
    .tv_index_o(tv_index), .tv_addr_o(tv_addr), .tv_valid_o(tv_valid),
    .hit_o(hit), .hit_way_o(hit_way), .miss_o, .data_o, .data_v_o
  );

  icache_tag_array #(.sets_p(sets_p)) tag_array_i (
    .clk_i, .reset_i, .rd_v_i(rd_v), .rd_index_i(rd_index), .tag_v_i,
    .tag_op_i, .tag_index_i, .tag_way_i, .tag_i, .tags_o(tags), .valid_o(valid)
  );

  icache_data_array #(.sets_p(sets_p)) data_array_i (
    .clk_i, .rd_v_i(rd_v), .rd_index_i(rd_index), .rd_word_i(rd_word),
    .fill_v_i, .fill_index_i, .fill_way_i, .fill_data_i, .words_o(words)
  );

  icache_lru #(.sets_p(sets_p)) lru_i (
    .clk_i, .reset_i, .rd_v_i(rd_v), .rd_index_i(rd_index), .tv_v_i(tv_v),
    .tv_index_i(tv_index), .hit_i(hit), .hit_way_i(hit_way),
    .way_valid_i(tv_valid), .repl_way_o(repl_way)
  );

  icache_miss_ctrl miss_ctrl_i (
    .clk_i, .reset_i, .miss_i(tv_miss), .tv_addr_i(tv_addr),
    .repl_way_i(repl_way), .cache_req_ready_i, .cache_req_complete_i,
    .cache_req_v_o, .cache_req_addr_o, .cache_req_metadata_v_o,
    .cache_req_repl_way_o, .miss_pending_o(miss_pending),
    .fetch_ready_o(fetch_ready)
  );

endmodule

`default_nettype wire

// ==== design/icache_data_array.sv ====
`default_nettype none

module icache_data_array #(
  parameter int sets_p = 64,
  localparam int index_width_lp = $clog2(sets_p),
  localparam int bank_addr_width_lp = index_width_lp + icache_pkg::word_offset_width_gp
) (
  input  wire                                          clk_i,
  input  wire                                          rd_v_i,
  input  wire  [index_width_lp-1:0]                    rd_index_i,
  input  wire  [icache_pkg::word_offset_width_gp-1:0]  rd_word_i,
  input  wire                                          fill_v_i,
  input  wire  [index_width_lp-1:0]                    fill_index_i,
  input  wire  [icache_pkg::way_id_width_gp-1:0]       fill_way_i,
  input  wire  [icache_pkg::block_width_gp-1:0]        fill_data_i,
  output logic [icache_pkg::ways_gp-1:0][icache_pkg::dword_width_gp-1:0] words_o
);

  localparam int bank_words_lp = sets_p * icache_pkg::block_words_gp;

  // one bank per way, block words at consecutive addresses
  logic [icache_pkg::dword_width_gp-1:0] bank_mem [icache_pkg::ways_gp][bank_words_lp];
  logic [bank_addr_width_lp-1:0]         rd_addr;
  logic                                  fill_we;

  assign rd_addr = {rd_index_i, rd_word_i};
  assign fill_we = fill_v_i & ~rd_v_i;

  // whole block lands in the named way's bank in one cycle
  always_ff @(posedge clk_i) begin
    if (fill_we) begin
      for (int k = 0; k < icache_pkg::block_words_gp; k++) begin
        bank_mem[fill_way_i][{fill_index_i, k[icache_pkg::word_offset_width_gp-1:0]}] <=
          fill_data_i[k*icache_pkg::dword_width_gp +: icache_pkg::dword_width_gp];
      end
    end
  end

  // same word from every way
  always_ff @(posedge clk_i) begin
    if (rd_v_i) begin
      for (int w = 0; w < icache_pkg::ways_gp; w++) begin
        words_o[w] <= bank_mem[w][rd_addr];
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/icache_lookup.sv ====
`default_nettype none

module icache_lookup #(
  parameter int sets_p = 64,
  localparam int index_width_lp = $clog2(sets_p),
  localparam int tag_width_lp = icache_pkg::paddr_width_gp - index_width_lp
                                - icache_pkg::block_offset_width_gp
) (
  input  wire                                          clk_i,
  input  wire                                          reset_i,
  input  wire                                          vaddr_v_i,
  input  wire  [icache_pkg::vaddr_width_gp-1:0]        vaddr_i,
  input  wire  [icache_pkg::ptag_width_gp-1:0]         ptag_i,
  input  wire                                          ptag_v_i,
  input  wire                                          poison_i,
  input  wire                                          fetch_ready_i,
  input  wire  [icache_pkg::ways_gp-1:0][tag_width_lp-1:0] tags_i,
  input  wire  [icache_pkg::ways_gp-1:0]               valid_i,
  input  wire  [icache_pkg::ways_gp-1:0][icache_pkg::dword_width_gp-1:0] words_i,
  input  wire                                          miss_pending_i,
  output logic                                         vaddr_ready_o,
  output logic                                         rd_v_o,
  output logic [index_width_lp-1:0]                    rd_index_o,
  output logic [icache_pkg::word_offset_width_gp-1:0]  rd_word_o,
  output logic                                         tv_v_o,
  output logic [index_width_lp-1:0]                    tv_index_o,
  output logic [icache_pkg::paddr_width_gp-1:0]        tv_addr_o,
  output logic [icache_pkg::ways_gp-1:0]               tv_valid_o,
  output logic                                         hit_o,
  output logic [icache_pkg::way_id_width_gp-1:0]       hit_way_o,
  output logic                                         miss_o,
  output logic [icache_pkg::instr_width_gp-1:0]        data_o,
  output logic                                         data_v_o
);

  localparam int pgoff_lp = icache_pkg::page_offset_width_gp;
  localparam int boff_lp = icache_pkg::block_offset_width_gp;

  logic                                        tl_v_r;
  logic [icache_pkg::vaddr_width_gp-1:0]       tl_vaddr_r;
  logic                                        tv_we;
  logic [icache_pkg::ways_gp-1:0][tag_width_lp-1:0] tv_tags_r;
  logic [icache_pkg::ways_gp-1:0][icache_pkg::dword_width_gp-1:0] tv_words_r;
  logic [tag_width_lp-1:0]                     tv_tag;
  logic [icache_pkg::ways_gp-1:0]              hit_vec;
  logic [icache_pkg::dword_width_gp-1:0]       hit_word;
  logic                                        tv_miss;

  // accept and launch the array reads
  assign vaddr_ready_o = fetch_ready_i;
  assign rd_v_o = vaddr_v_i & fetch_ready_i;
  assign rd_index_o = vaddr_i[boff_lp +: index_width_lp];
  assign rd_word_o = vaddr_i[icache_pkg::byte_offset_width_gp +:
                             icache_pkg::word_offset_width_gp];

  // TL stage
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tl_v_r <= 1'b0;
    end else begin
      tl_v_r <= rd_v_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_v_o) begin
      tl_vaddr_r <= vaddr_i;
    end
  end

  // ptag arrives with the TL cycle
  assign tv_we = tl_v_r & ptag_v_i & ~poison_i;

  // TV stage
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tv_v_o <= 1'b0;
    end else begin
      tv_v_o <= tv_we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tv_we) begin
      tv_addr_o  <= {ptag_i, tl_vaddr_r[pgoff_lp-1:0]};
      tv_tags_r  <= tags_i;
      tv_valid_o <= valid_i;
      tv_words_r <= words_i;
    end
  end

  assign tv_index_o = tv_addr_o[boff_lp +: index_width_lp];
  assign tv_tag = tv_addr_o[icache_pkg::paddr_width_gp-1 -: tag_width_lp];

  // tag compare
  always_comb begin
    for (int w = 0; w < icache_pkg::ways_gp; w++) begin
      hit_vec[w] = tv_valid_o[w] & (tv_tags_r[w] == tv_tag);
    end
  end

  // lowest matching way wins
  always_comb begin
    hit_way_o = '0;
    for (int w = icache_pkg::ways_gp - 1; w >= 0; w--) begin
      if (hit_vec[w]) begin
        hit_way_o = w[icache_pkg::way_id_width_gp-1:0];
      end
    end
  end

  assign hit_o = tv_v_o & (|hit_vec);
  assign tv_miss = tv_v_o & ~(|hit_vec);
  assign miss_o = tv_miss | miss_pending_i;

  // bit 2 picks the instruction half
  assign hit_word = tv_words_r[hit_way_o];
  assign data_o = tv_addr_o[icache_pkg::byte_offset_width_gp-1]
                ? hit_word[icache_pkg::instr_width_gp +: icache_pkg::instr_width_gp]
                : hit_word[icache_pkg::instr_width_gp-1:0];
  assign data_v_o = hit_o;

endmodule

`default_nettype wire

// ==== design/icache_lru.sv ====
`default_nettype none

module icache_lru #(
  parameter int sets_p = 64,
  localparam int index_width_lp = $clog2(sets_p)
) (
  input  wire                                     clk_i,
  input  wire                                     reset_i,
  input  wire                                     rd_v_i,
  input  wire  [index_width_lp-1:0]               rd_index_i,
  input  wire                                     tv_v_i,
  input  wire  [index_width_lp-1:0]               tv_index_i,
  input  wire                                     hit_i,
  input  wire  [icache_pkg::way_id_width_gp-1:0]  hit_way_i,
  input  wire  [icache_pkg::ways_gp-1:0]          way_valid_i,
  output logic [icache_pkg::way_id_width_gp-1:0]  repl_way_o
);

  logic [icache_pkg::lru_width_gp-1:0]    lru_r [sets_p];
  logic [index_width_lp-1:0]              tl_index_r;
  logic [icache_pkg::lru_width_gp-1:0]    tl_lru;
  logic [icache_pkg::lru_width_gp-1:0]    tv_lru_r;
  logic [icache_pkg::lru_width_gp-1:0]    hit_lru;
  logic [icache_pkg::way_id_width_gp-1:0] tree_way;
  logic                                   lru_we;

  assign lru_we = tv_v_i & hit_i;

  // point the tree away from the way just hit
  always_comb begin
    hit_lru = lru_r[tv_index_i];
    hit_lru[0] = ~hit_way_i[1];
    if (hit_way_i[1]) begin
      hit_lru[2] = ~hit_way_i[0];
    end else begin
      hit_lru[1] = ~hit_way_i[0];
    end
  end

  // forward a same-set update that lands on this edge
  assign tl_lru = (lru_we && tv_index_i == tl_index_r) ? hit_lru : lru_r[tl_index_r];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets_p; s++) begin
        lru_r[s] <= '0;
      end
    end else if (lru_we) begin
      lru_r[tv_index_i] <= hit_lru;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_v_i) begin
      tl_index_r <= rd_index_i;
    end
    tv_lru_r <= tl_lru;
  end

  assign tree_way = tv_lru_r[0] ? {1'b1, tv_lru_r[2]} : {1'b0, tv_lru_r[1]};

  // lowest invalid way beats the tree
  always_comb begin
    repl_way_o = tree_way;
    for (int w = icache_pkg::ways_gp - 1; w >= 0; w--) begin
      if (!way_valid_i[w]) begin
        repl_way_o = w[icache_pkg::way_id_width_gp-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/icache_miss_ctrl.sv ====
`default_nettype none

module icache_miss_ctrl (
  input  wire                                     clk_i,
  input  wire                                     reset_i,
  input  wire                                     miss_i,
  input  wire  [icache_pkg::paddr_width_gp-1:0]   tv_addr_i,
  input  wire  [icache_pkg::way_id_width_gp-1:0]  repl_way_i,
  input  wire                                     cache_req_ready_i,
  input  wire                                     cache_req_complete_i,
  output logic                                    cache_req_v_o,
  output logic [icache_pkg::paddr_width_gp-1:0]   cache_req_addr_o,
  output logic                                    cache_req_metadata_v_o,
  output logic [icache_pkg::way_id_width_gp-1:0]  cache_req_repl_way_o,
  output logic                                    miss_pending_o,
  output logic                                    fetch_ready_o
);

  logic tracker_r;

  // one request per outstanding miss
  assign cache_req_v_o = miss_i & cache_req_ready_i & ~tracker_r;
  assign cache_req_addr_o = {tv_addr_i[icache_pkg::paddr_width_gp-1:
                                       icache_pkg::block_offset_width_gp],
                             {icache_pkg::block_offset_width_gp{1'b0}}};

  // metadata beat trails the request by one cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cache_req_metadata_v_o <= 1'b0;
    end else begin
      cache_req_metadata_v_o <= cache_req_v_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cache_req_v_o) begin
      cache_req_repl_way_o <= repl_way_i;
    end
  end

  // held from request until the fill completes
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tracker_r <= 1'b0;
    end else if (cache_req_v_o) begin
      tracker_r <= 1'b1;
    end else if (cache_req_complete_i) begin
      tracker_r <= 1'b0;
    end
  end

  assign miss_pending_o = cache_req_v_o | tracker_r;
  assign fetch_ready_o = cache_req_ready_i & ~miss_pending_o;

endmodule

`default_nettype wire

// ==== design/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

  // cache geometry
  localparam int ways_gp = 4;
  localparam int way_id_width_gp = 2;
  localparam int lru_width_gp = ways_gp - 1;

  // word and block sizes
  localparam int dword_width_gp = 64;
  localparam int instr_width_gp = 32;
  localparam int block_words_gp = 4;
  localparam int block_width_gp = 256;

  // address fields
  localparam int byte_offset_width_gp = 3;
  localparam int word_offset_width_gp = 2;
  localparam int block_offset_width_gp = byte_offset_width_gp + word_offset_width_gp;
  localparam int page_offset_width_gp = 12;
  localparam int vaddr_width_gp = 32;
  localparam int paddr_width_gp = 32;
  localparam int ptag_width_gp = paddr_width_gp - page_offset_width_gp;

  // tag packet opcodes from the coherence side
  typedef enum logic [1:0] {
    tag_op_clear_set,
    tag_op_invalidate,
    tag_op_set_tag
  } tag_op_e;

endpackage

`default_nettype wire

// ==== design/icache_tag_array.sv ====
`default_nettype none

module icache_tag_array #(
  parameter int sets_p = 64,
  localparam int index_width_lp = $clog2(sets_p),
  localparam int tag_width_lp = icache_pkg::paddr_width_gp - index_width_lp
                                - icache_pkg::block_offset_width_gp
) (
  input  wire                                     clk_i,
  input  wire                                     reset_i,
  input  wire                                     rd_v_i,
  input  wire  [index_width_lp-1:0]               rd_index_i,
  input  wire                                     tag_v_i,
  input  wire  icache_pkg::tag_op_e               tag_op_i,
  input  wire  [index_width_lp-1:0]               tag_index_i,
  input  wire  [icache_pkg::way_id_width_gp-1:0]  tag_way_i,
  input  wire  [tag_width_lp-1:0]                 tag_i,
  output logic [icache_pkg::ways_gp-1:0][tag_width_lp-1:0] tags_o,
  output logic [icache_pkg::ways_gp-1:0]          valid_o
);

  logic [icache_pkg::ways_gp-1:0][tag_width_lp-1:0] tag_mem [sets_p];
  logic [icache_pkg::ways_gp-1:0]                   valid_r [sets_p];
  logic                                             tag_we;

  // fetch reads win the port
  assign tag_we = tag_v_i & ~rd_v_i;

  // valid bits per set, all cleared together on reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets_p; s++) begin
        valid_r[s] <= '0;
      end
    end else if (tag_we) begin
      case (tag_op_i)
        icache_pkg::tag_op_clear_set:  valid_r[tag_index_i] <= '0;
        icache_pkg::tag_op_invalidate: valid_r[tag_index_i][tag_way_i] <= 1'b0;
        icache_pkg::tag_op_set_tag:    valid_r[tag_index_i][tag_way_i] <= 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (tag_we && tag_op_i == icache_pkg::tag_op_set_tag) begin
      tag_mem[tag_index_i][tag_way_i] <= tag_i;
    end
    if (rd_v_i) begin
      tags_o  <= tag_mem[rd_index_i];
      valid_o <= valid_r[rd_index_i];
    end
  end

endmodule

`default_nettype wire

// ==== icache.f ====
design/icache_pkg.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_lru.sv
design/icache_miss_ctrl.sv
design/icache_lookup.sv
design/icache.sv
test/icache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the icache testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module icache_tb -f icache.f -o icache_sim
./obj_dir/icache_sim > sim.log
cat sim.log

if grep -qx "Test OK" sim.log; then
  exit 0
fi
exit 1

// ==== test/icache_tb.sv ====
`default_nettype none

module icache_tb;

  logic                clk_i = 1'b0;
  logic                reset_i;
  logic                vaddr_v_i;
  logic [31:0]         vaddr_i;
  logic                vaddr_ready_o;
  logic [19:0]         ptag_i;
  logic                ptag_v_i;
  logic                poison_i;
  logic [31:0]         data_o;
  logic                data_v_o;
  logic                miss_o;
  logic                cache_req_v_o;
  logic [31:0]         cache_req_addr_o;
  logic                cache_req_ready_i;
  logic                cache_req_metadata_v_o;
  logic [1:0]          cache_req_repl_way_o;
  logic                cache_req_complete_i;
  logic                tag_v_i;
  icache_pkg::tag_op_e tag_op_i;
  logic [5:0]          tag_index_i;
  logic [1:0]          tag_way_i;
  logic [20:0]         tag_i;
  logic                tag_ready_o;
  logic                fill_v_i;
  logic [5:0]          fill_index_i;
  logic [1:0]          fill_way_i;
  logic [255:0]        fill_data_i;
  logic                fill_ready_o;

  // shadow copy of the cache contents
  logic [20:0] tag_m [64][4];
  logic        valid_m [64][4];
  logic [63:0] word_m [64][4][4];
  logic [2:0]  lru_m [64];

  // fetches followed through TL and TV
  logic        tl_v;
  logic [31:0] tl_vaddr;
  logic        tv_v;
  logic [31:0] tv_addr;
  logic        meta_v;
  logic [1:0]  meta_way;
  logic        pend;
  logic        hit;
  logic        req;
  logic        accepted;
  logic [1:0]  hit_way;
  logic [1:0]  victim;
  logic [5:0]  row;
  logic [63:0] word;
  logic [31:0] instr;

  logic [31:0] fetch_q [$];
  logic        poison_q [$];
  string       test_name;
  int          test_errors;
  int          errors;
  int          passed;
  int          failed;
  int          cycles;
  integer      seed = 32'h2d4b5335;

  icache dut_i (.*);

  always #5 clk_i = ~clk_i;

  // whole run is a few hundred cycles
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == 3000) begin
      $display("timeout: the run did not finish within 3000 cycles");
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic note_error(input string what, input logic [63:0] exp, input logic [63:0] act);
    errors++;
    test_errors++;
    $display("error %s %s: expected %0h, actual %0h", test_name, what, exp, act);
  endtask

  // outputs are settled at the falling edge
  always @(negedge clk_i) begin
    if (reset_i) begin
      tl_v = 1'b0;
      tv_v = 1'b0;
      tv_addr = '0;
      meta_v = 1'b0;
      pend = 1'b0;
      for (int s = 0; s < 64; s++) begin
        lru_m[s] = '0;
        for (int w = 0; w < 4; w++) begin
          valid_m[s][w] = 1'b0;
        end
      end
    end else begin
      assert (cache_req_metadata_v_o == meta_v)
        else note_error("metadata_v", 64'(meta_v), 64'(cache_req_metadata_v_o));
      if (meta_v) begin
        assert (cache_req_repl_way_o == meta_way)
          else note_error("repl_way", 64'(meta_way), 64'(cache_req_repl_way_o));
      end
      row = tv_addr[10:5];
      hit = 1'b0;
      hit_way = 2'd0;
      for (int w = 3; w >= 0; w--) begin
        if (valid_m[row][w] && tag_m[row][w] == tv_addr[31:11]) begin
          hit = 1'b1;
          hit_way = w[1:0];
        end
      end
      // invalid ways go before the tree choice
      victim = lru_m[row][0] ? {1'b1, lru_m[row][2]} : {1'b0, lru_m[row][1]};
      for (int w = 3; w >= 0; w--) begin
        if (!valid_m[row][w]) victim = w[1:0];
      end
      hit = hit & tv_v;
      req = tv_v & ~hit & cache_req_ready_i & ~pend;
      word = word_m[row][hit_way][tv_addr[4:3]];
      instr = tv_addr[2] ? word[63:32] : word[31:0];
      assert (data_v_o == hit) else note_error("data_v", 64'(hit), 64'(data_v_o));
      if (hit) begin
        assert (data_o == instr) else note_error("data", 64'(instr), 64'(data_o));
        lru_m[row][0] = ~hit_way[1];
        if (hit_way[1]) lru_m[row][2] = ~hit_way[0];
        else lru_m[row][1] = ~hit_way[0];
      end
      assert (miss_o == ((tv_v & ~hit) | pend))
        else note_error("miss", 64'((tv_v & ~hit) | pend), 64'(miss_o));
      assert (cache_req_v_o == req) else note_error("req_v", 64'(req), 64'(cache_req_v_o));
      if (req) begin
        assert (cache_req_addr_o == {tv_addr[31:5], 5'b0})
          else note_error("req_addr", 64'({tv_addr[31:5], 5'b0}), 64'(cache_req_addr_o));
      end
      assert (vaddr_ready_o == (cache_req_ready_i & ~pend & ~req))
        else note_error("vaddr_ready", 64'(cache_req_ready_i & ~pend & ~req),
                        64'(vaddr_ready_o));
      accepted = vaddr_v_i & cache_req_ready_i & ~pend & ~req;
      assert ({tag_ready_o, fill_ready_o} == {2{~accepted}})
        else note_error("packet_ready", 64'({2{~accepted}}), 64'({tag_ready_o, fill_ready_o}));
      if (tag_v_i && !accepted) begin
        case (tag_op_i)
          icache_pkg::tag_op_clear_set: begin
            for (int w = 0; w < 4; w++) begin
              valid_m[tag_index_i][w] = 1'b0;
            end
          end
          icache_pkg::tag_op_invalidate: valid_m[tag_index_i][tag_way_i] = 1'b0;
          icache_pkg::tag_op_set_tag: begin
            valid_m[tag_index_i][tag_way_i] = 1'b1;
            tag_m[tag_index_i][tag_way_i] = tag_i;
          end
          default: ;
        endcase
      end
      if (fill_v_i && !accepted) begin
        for (int k = 0; k < 4; k++) begin
          word_m[fill_index_i][fill_way_i][k] = fill_data_i[k*64 +: 64];
        end
      end
      // advance the tracked pipeline
      meta_v = req;
      meta_way = victim;
      if (req) pend = 1'b1;
      else if (cache_req_complete_i) pend = 1'b0;
      tv_v = tl_v & ptag_v_i & ~poison_i;
      tv_addr = {ptag_i, tl_vaddr[11:0]};
      tl_v = accepted;
      tl_vaddr = vaddr_i;
    end
  end

  function automatic logic [31:0] make_addr(input logic [20:0] tag, input logic [5:0] idx,
                                            input logic [2:0] instr_sel);
    return {tag, idx, instr_sel, 2'b00};
  endfunction

  task automatic tick();
    @(posedge clk_i);
    #1;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    if (test_errors == 0) passed++;
    else failed++;
    $display("test %s: %s, %0d errors", test_name, test_errors == 0 ? "passed" : "failed",
             test_errors);
  endtask

  task automatic send_tag(input icache_pkg::tag_op_e op, input logic [5:0] idx,
                          input logic [1:0] way);
    tag_v_i = 1'b1;
    tag_op_i = op;
    tag_index_i = idx;
    tag_way_i = way;
    tick();
    tag_v_i = 1'b0;
  endtask

  // tag and block of one line in the same cycle
  task automatic load_line(input logic [20:0] tag, input logic [5:0] idx, input logic [1:0] way);
    logic [255:0] blk;
    for (int k = 0; k < 8; k++) begin
      blk[k*32 +: 32] = $random(seed);
    end
    tag_i = tag;
    fill_v_i = 1'b1;
    fill_index_i = idx;
    fill_way_i = way;
    fill_data_i = blk;
    send_tag(icache_pkg::tag_op_set_tag, idx, way);
    fill_v_i = 1'b0;
  endtask

  task automatic queue_fetch(input logic [31:0] addr, input logic poison);
    fetch_q.push_back(addr);
    poison_q.push_back(poison);
  endtask

  // back to back fetches, ptag follows each one by a cycle
  task automatic fetch_batch();
    int n;
    logic [31:0] prev;
    n = fetch_q.size();
    while (!vaddr_ready_o) tick();
    for (int i = 0; i <= n; i++) begin
      vaddr_v_i = (i < n);
      if (i < n) vaddr_i = fetch_q[i];
      ptag_v_i = (i > 0);
      if (i > 0) begin
        prev = fetch_q[i-1];
        ptag_i = prev[31:12];
        poison_i = poison_q[i-1];
      end
      tick();
    end
    ptag_v_i = 1'b0;
    poison_i = 1'b0;
    tick();
    fetch_q.delete();
    poison_q.delete();
  endtask

  task automatic resolve_miss();
    while (!cache_req_metadata_v_o) tick();
    repeat (3) tick();
    cache_req_complete_i = 1'b1;
    tick();
    cache_req_complete_i = 1'b0;
  endtask

  initial begin
    reset_i = 1'b1;
    vaddr_v_i = 1'b0;
    vaddr_i = '0;
    ptag_i = '0;
    ptag_v_i = 1'b0;
    poison_i = 1'b0;
    cache_req_ready_i = 1'b1;
    cache_req_complete_i = 1'b0;
    tag_v_i = 1'b0;
    tag_op_i = icache_pkg::tag_op_clear_set;
    tag_index_i = '0;
    tag_way_i = '0;
    tag_i = '0;
    fill_v_i = 1'b0;
    fill_index_i = '0;
    fill_way_i = '0;
    fill_data_i = '0;
    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    start_test("reset_miss");
    queue_fetch(make_addr(21'd5, 6'd3, 3'd1), 1'b0);
    fetch_batch();
    resolve_miss();
    finish_test();

    start_test("fill_hit");
    load_line(21'd5, 6'd3, 2'd1);
    for (int i = 0; i < 8; i++) begin
      queue_fetch(make_addr(21'd5, 6'd3, i[2:0]), 1'b0);
      fetch_batch();
    end
    finish_test();

    start_test("stream_poison");
    for (int i = 0; i < 8; i++) begin
      queue_fetch(make_addr(21'd5, 6'd3, 3'(7 - i)), i == 3);
    end
    fetch_batch();
    finish_test();

    start_test("invalid_first");
    for (int w = 0; w < 4; w++) begin
      load_line(21'(10 + w), 6'd9, w[1:0]);
    end
    send_tag(icache_pkg::tag_op_invalidate, 6'd9, 2'd2);
    queue_fetch(make_addr(21'd20, 6'd9, 3'd0), 1'b0);
    fetch_batch();
    resolve_miss();
    send_tag(icache_pkg::tag_op_clear_set, 6'd9, 2'd0);
    queue_fetch(make_addr(21'd20, 6'd9, 3'd4), 1'b0);
    fetch_batch();
    resolve_miss();
    finish_test();

    start_test("lru_victim");
    for (int w = 0; w < 4; w++) begin
      load_line(21'(30 + w), 6'd17, w[1:0]);
    end
    queue_fetch(make_addr(21'd32, 6'd17, 3'd0), 1'b0);
    queue_fetch(make_addr(21'd30, 6'd17, 3'd2), 1'b0);
    queue_fetch(make_addr(21'd33, 6'd17, 3'd5), 1'b0);
    fetch_batch();
    queue_fetch(make_addr(21'd40, 6'd17, 3'd0), 1'b0);
    fetch_batch();
    resolve_miss();
    finish_test();

    // fetch held off while packets still go in
    start_test("backpressure");
    while (!vaddr_ready_o) tick();
    vaddr_v_i = 1'b1;
    vaddr_i = make_addr(21'd60, 6'd25, 3'd0);
    tick();
    vaddr_v_i = 1'b0;
    ptag_v_i = 1'b1;
    ptag_i = vaddr_i[31:12];
    tick();
    // this miss reaches TV with the request path blocked
    ptag_v_i = 1'b0;
    cache_req_ready_i = 1'b0;
    vaddr_v_i = 1'b1;
    vaddr_i = make_addr(21'd50, 6'd25, 3'd0);
    tick();
    tick();
    load_line(21'd50, 6'd25, 2'd0);
    tick();
    vaddr_v_i = 1'b0;
    cache_req_ready_i = 1'b1;
    tick();
    queue_fetch(make_addr(21'd50, 6'd25, 3'd0), 1'b0);
    queue_fetch(make_addr(21'd50, 6'd25, 3'd5), 1'b0);
    fetch_batch();
    finish_test();

    $display("%0d tests, %0d passed, %0d failed, %0d errors", passed + failed, passed, failed,
             errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
